// ==== common/wb_pkg.sv ====
package wb_pkg;

  localparam int WB_AW = 32;
  localparam int WB_DW = 16;

  // Master to slave.
  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [1:0]       sel;
    logic [WB_AW-1:0] adr;
    logic [WB_DW-1:0] dat;
  } wb_req_t;

  // Slave to master.
  typedef struct packed {
    logic             ack;
    logic             err;
    logic [WB_DW-1:0] dat;
  } wb_rsp_t;

endpackage

// ==== common/bridge_pkg.sv ====
package bridge_pkg;

  // ------------------------------------------------------------------------
  // Host command bytes
  // ------------------------------------------------------------------------
  localparam logic [7:0] CMD_NOP   = 8'd0;
  localparam logic [7:0] CMD_READ  = 8'd1;
  localparam logic [7:0] CMD_WRITE = 8'd2;

  // Returned to the host when a read ends in a bus error.
  localparam logic [15:0] ERR_WORD = 16'hBAD0;

  // ------------------------------------------------------------------------
  // Handshake payloads
  // ------------------------------------------------------------------------

  // Decoded command, decoder to master.
  typedef struct packed {
    logic        we;     // 1 = write.
    logic [31:0] addr;
    logic [15:0] wdata;
  } cmd_t;

  // Read result, master to serializer.
  typedef struct packed {
    logic [15:0] rdata;
  } rsp_t;

endpackage

// ==== bridge/cmd_decoder.sv ====
`timescale 1ns/10ps

module cmd_decoder import bridge_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] data_i,
  input  logic       dstrb_i,
  output logic       busy_o,
  output logic       soft_reset_o,
  output logic       cmd_req_o,
  output cmd_t       cmd_o,
  input  logic       cmd_ack_i
);

  typedef enum logic [2:0] {
    ST_CMD,
    ST_ADDR,
    ST_DATA,
    ST_REQ,
    ST_RELEASE
  } state_t;

  state_t     state;
  logic [1:0] byte_cnt;
  logic [3:0] nop_cnt;
  logic       take;
  cmd_t       cmd_q;

  assign busy_o = (state == ST_REQ) || (state == ST_RELEASE);
  assign take   = dstrb_i && !busy_o;  // Bytes seen while busy are dropped.
  assign cmd_o  = cmd_q;

  // --------------------------------------------------------------------------
  // Byte collection
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (take) begin
      case (state)
        ST_CMD:  cmd_q.we <= (data_i == CMD_WRITE);
        ST_ADDR: cmd_q.addr[{byte_cnt, 3'b000} +: 8] <= data_i;  // LSB first.
        ST_DATA: cmd_q.wdata[{byte_cnt[0], 3'b000} +: 8] <= data_i;
        default: ;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Control FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= ST_CMD;
      byte_cnt     <= 2'd0;
      nop_cnt      <= 4'd0;
      cmd_req_o    <= 1'b0;
      soft_reset_o <= 1'b0;
    end else begin
      soft_reset_o <= 1'b0;
      if (take) nop_cnt <= 4'd0;  // Any byte but a NOP breaks the run.
      case (state)
        ST_CMD: begin
          if (take) begin
            byte_cnt <= 2'd0;
            if (data_i == CMD_NOP) begin
              nop_cnt <= nop_cnt + 4'd1;  // Wraps to zero on the sixteenth.
              if (nop_cnt == 4'hF) soft_reset_o <= 1'b1;
            end else if (data_i == CMD_READ || data_i == CMD_WRITE) begin
              state <= ST_ADDR;
            end
          end
        end
        ST_ADDR: begin
          if (take) begin
            byte_cnt <= byte_cnt + 2'd1;
            if (byte_cnt == 2'd3) begin
              if (cmd_q.we) begin
                state <= ST_DATA;
              end else begin
                cmd_req_o <= 1'b1;
                state     <= ST_REQ;
              end
            end
          end
        end
        ST_DATA: begin
          if (take) begin
            byte_cnt <= byte_cnt + 2'd1;
            if (byte_cnt[0]) begin  // High data byte.
              cmd_req_o <= 1'b1;
              state     <= ST_REQ;
            end
          end
        end
        ST_REQ: begin
          if (cmd_ack_i) begin
            cmd_req_o <= 1'b0;
            state     <= ST_RELEASE;
          end
        end
        ST_RELEASE: begin
          if (!cmd_ack_i) state <= ST_CMD;
        end
        default: state <= ST_CMD;
      endcase
    end
  end

endmodule

// ==== bridge/resp_serializer.sv ====
`timescale 1ns/10ps

module resp_serializer import bridge_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       rsp_req_i,
  input  rsp_t       rsp_i,
  output logic       rsp_ack_o,
  input  logic       busy_i,
  output logic [7:0] data_o,
  output logic       dstrb_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOW,
    ST_GAP,
    ST_HIGH,
    ST_DONE
  } state_t;

  state_t      state;
  logic [15:0] word_q;

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && rsp_req_i) word_q <= rsp_i.rdata;
    if (state == ST_LOW && !busy_i) data_o <= word_q[7:0];
    if (state == ST_HIGH && !busy_i) data_o <= word_q[15:8];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      rsp_ack_o <= 1'b0;
      dstrb_o   <= 1'b0;
    end else begin
      dstrb_o <= 1'b0;
      case (state)
        ST_IDLE: if (rsp_req_i) state <= ST_LOW;
        ST_LOW: begin
          if (!busy_i) begin
            dstrb_o <= 1'b1;
            state   <= ST_GAP;
          end
        end
        ST_GAP:  state <= ST_HIGH;  // One idle cycle between the bytes.
        ST_HIGH: begin
          if (!busy_i) begin
            dstrb_o   <= 1'b1;
            rsp_ack_o <= 1'b1;  // Word fully sent.
            state     <= ST_DONE;
          end
        end
        ST_DONE: begin
          if (!rsp_req_i) begin
            rsp_ack_o <= 1'b0;
            state     <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== bridge/wb_master.sv ====
`timescale 1ns/10ps

module wb_master import bridge_pkg::*, wb_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    cmd_req_i,
  input  cmd_t    cmd_i,
  output logic    cmd_ack_o,
  output logic    rsp_req_o,
  output rsp_t    rsp_o,
  input  logic    rsp_ack_i,
  output wb_req_t wb_req_o,
  input  wb_rsp_t wb_rsp_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUS,
    ST_RESPOND,
    ST_ACK
  } state_t;

  state_t           state;
  logic             cyc_q;
  logic             we_q;
  logic [WB_AW-1:0] adr_q;
  logic [WB_DW-1:0] dat_q;
  rsp_t             rsp_q;
  logic             bus_done;

  assign bus_done = wb_rsp_i.ack || wb_rsp_i.err;
  assign rsp_o    = rsp_q;
  assign wb_req_o = '{cyc: cyc_q, stb: cyc_q, we: we_q, sel: 2'b11,
                      adr: adr_q, dat: dat_q};

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && cmd_req_i) begin
      we_q  <= cmd_i.we;
      adr_q <= cmd_i.addr;
      dat_q <= cmd_i.wdata;
    end
    if (state == ST_BUS && bus_done && !we_q)
      rsp_q.rdata <= wb_rsp_i.err ? ERR_WORD : wb_rsp_i.dat;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      cyc_q     <= 1'b0;
      cmd_ack_o <= 1'b0;
      rsp_req_o <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (cmd_req_i) begin
            cyc_q <= 1'b1;
            state <= ST_BUS;
          end
        end
        ST_BUS: begin
          if (bus_done) begin
            cyc_q <= 1'b0;
            if (we_q) begin
              cmd_ack_o <= 1'b1;  // Write errors are not reported.
              state     <= ST_ACK;
            end else begin
              rsp_req_o <= 1'b1;
              state     <= ST_RESPOND;
            end
          end
        end
        ST_RESPOND: begin
          if (rsp_ack_i) begin
            rsp_req_o <= 1'b0;
            cmd_ack_o <= 1'b1;
            state     <= ST_ACK;
          end
        end
        ST_ACK: begin
          // Both handshakes must be back to rest.
          if (!cmd_req_i && !rsp_ack_i) begin
            cmd_ack_o <= 1'b0;
            state     <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== src/wb_ram.sv ====
`timescale 1ns/10ps

module wb_ram import wb_pkg::*; #(
  parameter int RAM_AW      = 6,
  parameter int WAIT_STATES = 2
) (
  input  logic    clk,
  input  logic    reset,
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o
);

  localparam int CW = $clog2(WAIT_STATES + 1);

  logic [WB_DW-1:0]  mem [2**RAM_AW];
  logic [CW-1:0]     wait_cnt;
  logic [RAM_AW-1:0] idx;
  logic              out_of_range;
  logic              active;
  logic              done;
  logic              ack_q;
  logic              err_q;
  logic [WB_DW-1:0]  dat_q;

  assign idx          = wb_req_i.adr[RAM_AW:1];  // Word address.
  assign out_of_range = |wb_req_i.adr[WB_AW-1:RAM_AW+1];
  assign active       = wb_req_i.cyc && wb_req_i.stb && !ack_q && !err_q;
  assign done         = active && (wait_cnt == CW'(WAIT_STATES - 1));
  assign wb_rsp_o     = '{ack: ack_q, err: err_q, dat: dat_q};

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (done) begin
      if (!out_of_range && wb_req_i.we && wb_req_i.sel == 2'b11)
        mem[idx] <= wb_req_i.dat;
      dat_q <= (out_of_range || wb_req_i.we) ? '0 : mem[idx];
    end
  end

  // --------------------------------------------------------------------------
  // Wait states and response
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      wait_cnt <= '0;
      ack_q    <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      ack_q <= done && !out_of_range;
      err_q <= done && out_of_range;
      if (done)
        wait_cnt <= '0;
      else if (active)
        wait_cnt <= wait_cnt + 1'b1;
    end
  end

endmodule

// ==== src/byte_wb_bridge.sv ====
`timescale 1ns/10ps

module byte_wb_bridge import bridge_pkg::*, wb_pkg::*; #(
  parameter int RAM_AW      = 6,
  parameter int WAIT_STATES = 2
) (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] data_i,
  input  logic       dstrb_i,
  output logic       busy_o,
  output logic [7:0] data_o,
  output logic       dstrb_o,
  input  logic       busy_i,
  output logic       soft_reset_o,
  output wb_req_t    wb_req_o,
  output wb_rsp_t    wb_rsp_o
);

  logic    cmd_req;
  logic    cmd_ack;
  cmd_t    cmd;
  logic    rsp_req;
  logic    rsp_ack;
  rsp_t    rsp;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;

  // Bus visible at the top for monitoring.
  assign wb_req_o = wb_req;
  assign wb_rsp_o = wb_rsp;

  cmd_decoder cmd_decoder_inst (
    .clk          (clk),
    .reset        (reset),
    .data_i       (data_i),
    .dstrb_i      (dstrb_i),
    .busy_o       (busy_o),
    .soft_reset_o (soft_reset_o),
    .cmd_req_o    (cmd_req),
    .cmd_o        (cmd),
    .cmd_ack_i    (cmd_ack)
  );

  wb_master wb_master_inst (
    .clk       (clk),
    .reset     (reset),
    .cmd_req_i (cmd_req),
    .cmd_i     (cmd),
    .cmd_ack_o (cmd_ack),
    .rsp_req_o (rsp_req),
    .rsp_o     (rsp),
    .rsp_ack_i (rsp_ack),
    .wb_req_o  (wb_req),
    .wb_rsp_i  (wb_rsp)
  );

  resp_serializer resp_serializer_inst (
    .clk       (clk),
    .reset     (reset),
    .rsp_req_i (rsp_req),
    .rsp_i     (rsp),
    .rsp_ack_o (rsp_ack),
    .busy_i    (busy_i),
    .data_o    (data_o),
    .dstrb_o   (dstrb_o)
  );

  wb_ram #(
    .RAM_AW      (RAM_AW),
    .WAIT_STATES (WAIT_STATES)
  ) wb_ram_inst (
    .clk      (clk),
    .reset    (reset),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp)
  );

endmodule

// ==== sim/byte_wb_bridge_tb.sv ====
`timescale 1ns/10ps

module byte_wb_bridge_tb import wb_pkg::*; ();

  localparam int          RAM_AW     = 6;
  localparam logic [7:0]  NOP        = 8'd0;
  localparam logic [7:0]  READ       = 8'd1;
  localparam logic [7:0]  WRITE      = 8'd2;
  localparam logic [15:0] ERR_MARK   = 16'hBAD0;
  localparam int          MAX_CYCLES = 20000;  // ~200 commands at 60 cycles, plus margin.

  logic       clk;
  logic       reset;
  logic [7:0] data_i;
  logic       dstrb_i;
  logic       busy_o;
  logic [7:0] data_o;
  logic       dstrb_o;
  logic       busy_i = 1'b0;
  logic       soft_reset_o;
  wb_req_t    wb_req_o;
  wb_rsp_t    wb_rsp_o;

  logic        bp_en = 1'b0;
  logic [7:0]  rx_q[$];
  logic [15:0] ref_mem[logic [RAM_AW-1:0]];
  int          errors     = 0;
  int          tests      = 0;
  int          cycles     = 0;
  int          err_cycles = 0;
  int          bus_cycles = 0;
  int          sr_pulses  = 0;

  byte_wb_bridge byte_wb_bridge_inst (
    .clk          (clk),
    .reset        (reset),
    .data_i       (data_i),
    .dstrb_i      (dstrb_i),
    .busy_o       (busy_o),
    .data_o       (data_o),
    .dstrb_o      (dstrb_o),
    .busy_i       (busy_i),
    .soft_reset_o (soft_reset_o),
    .wb_req_o     (wb_req_o),
    .wb_rsp_o     (wb_rsp_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Host back-pressure, busy about three cycles in four.
  always @(negedge clk) busy_i <= bp_en && ($urandom % 4 != 0);

  // --------------------------------------------------------------------------
  // Monitors and timeout
  // --------------------------------------------------------------------------
  always @(posedge clk) begin
    if (!reset && dstrb_o) rx_q.push_back(data_o);
    if (wb_rsp_o.err) err_cycles <= err_cycles + 1;
    if (wb_rsp_o.ack || wb_rsp_o.err) bus_cycles <= bus_cycles + 1;
    if (soft_reset_o) sr_pulses <= sr_pulses + 1;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout after %0d cycles, a handshake never completed.", MAX_CYCLES);
      $display("sim failed");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Bus and stream assertions
  // --------------------------------------------------------------------------
  assert property (@(posedge clk) disable iff (reset)
    wb_req_o.cyc && !wb_rsp_o.ack && !wb_rsp_o.err |=>
      $stable({wb_req_o.stb, wb_req_o.we, wb_req_o.adr, wb_req_o.dat}))
    else begin
      errors++;
      $display("%0t: bus request changed before ack or err", $time);
    end

  assert property (@(posedge clk) wb_req_o.sel == 2'b11)
    else begin
      errors++;
      $display("%0t: sel is not both byte lanes", $time);
    end

  assert property (@(posedge clk) disable iff (reset) !(wb_rsp_o.ack && wb_rsp_o.err))
    else begin
      errors++;
      $display("%0t: ack and err high in the same cycle", $time);
    end

  assert property (@(posedge clk) disable iff (reset) dstrb_o |-> !$past(busy_i))
    else begin
      errors++;
      $display("%0t: byte strobed after a cycle with busy_i high", $time);
    end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, got);
    end
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("test %0d %s done, %0d errors so far", tests, name, errors);
  endtask

  function automatic logic [31:0] random_in_range();
    return $urandom & ((32'd1 << (RAM_AW + 1)) - 32'd1);
  endfunction

  // Same word index, but one bit above the RAM range set.
  function automatic logic [31:0] set_high_bit(input logic [31:0] addr);
    return addr | (32'd1 << (RAM_AW + 1 + $urandom % (31 - RAM_AW)));
  endfunction

  function automatic logic [15:0] expect_word(input logic [31:0] addr);
    if (addr[31:RAM_AW+1] != '0) return ERR_MARK;
    return ref_mem[addr[RAM_AW:1]];
  endfunction

  task automatic send_byte(input logic [7:0] b);
    while (busy_o) @(negedge clk);
    data_i  = b;
    dstrb_i = 1'b1;
    @(negedge clk);
    dstrb_i = 1'b0;
  endtask

  task automatic send_addr(input logic [31:0] addr);
    for (int i = 0; i < 4; i++) send_byte(addr[8*i +: 8]);  // LSB first.
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [15:0] data);
    send_byte(WRITE);
    send_addr(addr);
    send_byte(data[7:0]);
    send_byte(data[15:8]);
    if (addr[31:RAM_AW+1] == '0) ref_mem[addr[RAM_AW:1]] = data;
  endtask

  task automatic read_word(input logic [31:0] addr);
    logic [15:0] exp;
    logic [7:0]  lo;
    logic [7:0]  hi;
    exp = expect_word(addr);
    send_byte(READ);
    send_addr(addr);
    while (rx_q.size() < 2) @(negedge clk);
    lo = rx_q.pop_front();
    hi = rx_q.pop_front();
    compare_value("data_o low byte", 32'(exp[7:0]), 32'(lo));
    compare_value("data_o high byte", 32'(exp[15:8]), 32'(hi));
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    int unsigned seed;
    int          base;
    logic [31:0] addr;
    seed    = $urandom(32'h274a);
    reset   = 1'b1;
    data_i  = 8'h00;
    dstrb_i = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    compare_value("dstrb_o", 0, 32'(dstrb_o));
    compare_value("busy_o", 0, 32'(busy_o));
    compare_value("soft_reset_o", 0, 32'(soft_reset_o));
    compare_value("wb_req_o.cyc", 0, 32'(wb_req_o.cyc));
    report_test("reset state");

    for (int i = 0; i < 2**RAM_AW; i++) write_word(32'(i) << 1, 16'($urandom));
    for (int i = 0; i < 40; i++) begin
      addr = random_in_range();
      if ($urandom % 2 == 0) write_word(addr, 16'($urandom));
      else read_word(addr);
    end
    report_test("write and read back");

    base = err_cycles;
    addr = random_in_range();
    read_word(set_high_bit(addr));
    write_word(set_high_bit(addr), 16'($urandom));
    read_word(addr);  // Must still hold the old word.
    compare_value("wb_rsp_o.err cycles", 2, 32'(err_cycles - base));
    report_test("error path");

    bp_en <= 1'b1;
    for (int i = 0; i < 30; i++) begin
      addr = random_in_range();
      if ($urandom % 4 == 0) write_word(addr, 16'($urandom));
      else if ($urandom % 8 == 0) read_word(set_high_bit(addr));
      else read_word(addr);
    end
    bp_en <= 1'b0;
    repeat (4) @(negedge clk);
    compare_value("extra data_o bytes", 0, 32'(rx_q.size()));
    report_test("back-pressure");

    base = sr_pulses;
    repeat (16) send_byte(NOP);
    repeat (3) @(negedge clk);
    compare_value("soft_reset_o pulses", 1, 32'(sr_pulses - base));
    base = sr_pulses;
    repeat (15) send_byte(NOP);
    read_word(random_in_range());  // Breaks the NOP run.
    repeat (15) send_byte(NOP);
    repeat (3) @(negedge clk);
    compare_value("soft_reset_o pulses", 0, 32'(sr_pulses - base));
    send_byte(NOP);
    repeat (3) @(negedge clk);
    compare_value("soft_reset_o pulses", 1, 32'(sr_pulses - base));
    report_test("soft reset");

    // Enough trailing bytes to complete a read or a write frame.
    base = bus_cycles;
    send_byte(8'h7F);
    repeat (6) send_byte(NOP);
    repeat (20) begin
      @(negedge clk);
      compare_value("wb_req_o.cyc", 0, 32'(wb_req_o.cyc));
    end
    compare_value("bus cycles", 0, 32'(bus_cycles - base));
    report_test("unknown command");

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== byte_wb_bridge.f ====
common/wb_pkg.sv
common/bridge_pkg.sv
bridge/cmd_decoder.sv
bridge/resp_serializer.sv
bridge/wb_master.sv
src/wb_ram.sv
src/byte_wb_bridge.sv
sim/byte_wb_bridge_tb.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' byte_wb_bridge.f)
BIN  := obj_dir/Vbyte_wb_bridge_tb

.PHONY: all run clean

all: run

$(BIN): byte_wb_bridge.f $(SRCS)
	verilator --binary --timing --assert -f byte_wb_bridge.f \
	  --top-module byte_wb_bridge_tb

run: $(BIN)
	$(BIN) | tee sim.log
	@if grep -q "sim failed" sim.log; then echo "FAIL"; exit 1; fi
	@grep -q "sim passed" sim.log || (echo "FAIL: no result line"; exit 1)
	@echo "PASS"

clean:
	rm -rf obj_dir sim.log
